/* verilog.f */
verilog/rv_core_pkg.sv
verilog/id_stage.sv
verilog/reg_file.sv
verilog/ex_stage.sv
verilog/int_core.sv
tests/int_core_checker.sv
tests/int_core_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module int_core_tb -Mdir obj_dir
	./obj_dir/Vint_core_tb +verilator+error+limit+1000 | tee sim.log
	grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/int_core_tb.sv */
/*
 int core testbench
 LFSR-built legal and illegal instructions over x0..x7 with random
 gaps, drained to the last retirement, closing report from the
 error count of the bound checker
 */

`timescale 1ns/10ps

module int_core_tb;

    localparam int NUM_INSTR   = 200;
    localparam int DRAIN_LIMIT = 20;

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    rv_core_pkg::instr_u  instr;
    rv_core_pkg::wb_req_t retire;
    logic                 illegal;

    logic [31:0] lfsr_q;
    int          issued_cnt = 0;
    int          done_cnt = 0;
    int          timeout_cnt = 0;
    int          error_cnt;
    int          wait_cycles;

    int_core #(
        .NUM_REGS(32)
    ) i_int_core (
        .clk          (clk),
        .rst_i        (rst),
        .instr_valid_i(instr_valid),
        .instr_i      (instr),
        .retire_o     (retire),
        .illegal_o    (illegal)
    );

    always #10 clk = ~clk;

    // one output event per issued word, either kind
    always @(posedge clk) begin
        if (!rst && (retire.we || illegal)) begin
            done_cnt++;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic build_instr(output rv_core_pkg::instr_u ins);
        logic [31:0] sel;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        take_bits(4, sel);
        take_bits(3, rd);
        take_bits(3, rs1);
        take_bits(3, rs2);
        take_bits(12, imm);
        // register ADD unless changed below
        ins = {7'b0000000, 2'b00, rs2[2:0], 2'b00, rs1[2:0], rv_core_pkg::F3_ADD,
               2'b00, rd[2:0], rv_core_pkg::OPC_OP};
        case (sel[3:0])
            4'd1: ins.r.funct7 = rv_core_pkg::F7_SUB;
            4'd2: ins.r.funct3 = rv_core_pkg::F3_AND;
            4'd3: ins.r.funct3 = rv_core_pkg::F3_OR;
            4'd4: ins.r.funct3 = rv_core_pkg::F3_XOR;
            4'd5: ins.r.funct3 = rv_core_pkg::F3_SLT;
            // unsupported funct7
            4'd12: ins.r.funct7 = 7'b0000001;
            // unsupported opcode
            4'd15: ins.r.opcode = 7'b0000011;
            4'd0, 4'd13: ;
            default: begin
                ins.i.opcode = rv_core_pkg::OPC_OP_IMM;
                ins.i.imm12  = imm[11:0];
                case (sel[3:0])
                    4'd7: ins.i.funct3 = rv_core_pkg::F3_SLT;
                    4'd8: ins.i.funct3 = rv_core_pkg::F3_XOR;
                    4'd9: ins.i.funct3 = rv_core_pkg::F3_OR;
                    4'd10: ins.i.funct3 = rv_core_pkg::F3_AND;
                    // shift immediate, unsupported
                    4'd14: ins.i.funct3 = 3'b001;
                    default: ins.i.funct3 = rv_core_pkg::F3_ADD;
                endcase
            end
        endcase
    endtask

    initial begin
        rv_core_pkg::instr_u ins;
        logic [31:0]         gap;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_q      = 32'd65707;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            build_instr(ins);
            instr_valid = 1'b1;
            instr       = ins;
            issued_cnt++;
            @(negedge clk);
            instr_valid = 1'b0;
            // half the words back to back
            take_bits(2, gap);
            if (gap > 1) begin
                repeat (gap - 1) @(negedge clk);
            end
        end
        wait_cycles = 0;
        while (done_cnt < issued_cnt && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (done_cnt < issued_cnt) begin
            timeout_cnt++;
            $display("timeout: only %0d of %0d instructions retired or flagged",
                     done_cnt, issued_cnt);
        end
        @(negedge clk);
        error_cnt = i_int_core.i_int_core_checker.fail_cnt;
        $display("errors: %0d  timeouts: %0d", error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tests/int_core_checker.sv */
/*
 int core checker
 shadow register model fed from the retirement port, a two-deep
 record of issued words and assertions on latency, results,
 illegal pulses and reset values, bound into int_core
 */

`timescale 1ns/10ps

module int_core_checker #(
    parameter int NUM_REGS = 32
) (
    input logic                 clk,
    input logic                 rst_i,
    input logic                 instr_valid_i,
    input rv_core_pkg::instr_u  instr_i,
    input rv_core_pkg::wb_req_t retire_i,
    input logic                 illegal_i
);

    typedef struct packed {
        logic                valid;
        rv_core_pkg::instr_u instr;
    } issue_t;

    int                     fail_cnt = 0;
    rv_core_pkg::reg_data_t shadow_q [32];
    // slot 1 is the word whose result is due at this edge
    issue_t                 iss_q [2];
    logic                   rst_q;
    rv_core_pkg::instr_u    ins;
    rv_core_pkg::reg_data_t op_a;
    rv_core_pkg::reg_data_t op_b;
    logic                   exp_legal;
    rv_core_pkg::reg_data_t exp_wdata;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                shadow_q[i] <= '0;
            end
            iss_q[0] <= '0;
            iss_q[1] <= '0;
        end else begin
            // x0 never takes a value
            if (retire_i.we && retire_i.rd != 5'd0) begin
                shadow_q[retire_i.rd] <= retire_i.wdata;
            end
            iss_q[0] <= '{valid: instr_valid_i, instr: instr_i};
            iss_q[1] <= iss_q[0];
        end
        rst_q <= rst_i;
    end

    // reference result from the shadow values, older results already applied
    always_comb begin
        ins       = iss_q[1].instr;
        op_a      = shadow_q[ins.r.rs1];
        op_b      = {{20{ins.i.imm12[11]}}, ins.i.imm12};
        exp_legal = (ins.r.opcode == rv_core_pkg::OPC_OP_IMM);
        if (ins.r.opcode == rv_core_pkg::OPC_OP) begin
            op_b      = shadow_q[ins.r.rs2];
            exp_legal = (ins.r.funct7 == 7'd0 || (ins.r.funct7 == rv_core_pkg::F7_SUB
                         && ins.r.funct3 == rv_core_pkg::F3_ADD))
                        && int'(ins.r.rs2) < NUM_REGS;
        end
        exp_legal = exp_legal && int'(ins.r.rd) < NUM_REGS && int'(ins.r.rs1) < NUM_REGS;
        case (ins.r.funct3)
            rv_core_pkg::F3_ADD: exp_wdata = (ins.r.opcode == rv_core_pkg::OPC_OP
                                              && ins.r.funct7 == rv_core_pkg::F7_SUB)
                                             ? op_a - op_b : op_a + op_b;
            rv_core_pkg::F3_SLT: exp_wdata = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            rv_core_pkg::F3_XOR: exp_wdata = op_a ^ op_b;
            rv_core_pkg::F3_OR:  exp_wdata = op_a | op_b;
            rv_core_pkg::F3_AND: exp_wdata = op_a & op_b;
            default: begin
                exp_wdata = '0;
                exp_legal = 1'b0;
            end
        endcase
    end

    // a retirement exactly two edges after each legal strobe
    a_retire_we: assert property (@(posedge clk) disable iff (rst_i)
        retire_i.we == (iss_q[1].valid && exp_legal))
        else begin
            fail_cnt++;
            $error("FAILED at %0t: retire_o.we expected %0b got %0b", $time,
                   $sampled(iss_q[1].valid && exp_legal), $sampled(retire_i.we));
        end

    a_retire_rd: assert property (@(posedge clk) disable iff (rst_i)
        retire_i.we |-> retire_i.rd == iss_q[1].instr.r.rd)
        else begin
            fail_cnt++;
            $error("FAILED at %0t: retire_o.rd expected %0d got %0d", $time,
                   $sampled(iss_q[1].instr.r.rd), $sampled(retire_i.rd));
        end

    a_retire_data: assert property (@(posedge clk) disable iff (rst_i)
        retire_i.we |-> retire_i.wdata == exp_wdata)
        else begin
            fail_cnt++;
            $error("FAILED at %0t: retire_o.wdata expected %h got %h", $time,
                   $sampled(exp_wdata), $sampled(retire_i.wdata));
        end

    // illegal pulse in place of the retirement
    a_illegal: assert property (@(posedge clk) disable iff (rst_i)
        illegal_i == (iss_q[1].valid && !exp_legal))
        else begin
            fail_cnt++;
            $error("FAILED at %0t: illegal_o expected %0b got %0b", $time,
                   $sampled(iss_q[1].valid && !exp_legal), $sampled(illegal_i));
        end

    a_reset_idle: assert property (@(posedge clk)
        rst_q |-> !retire_i.we && !illegal_i)
        else begin
            fail_cnt++;
            $error("FAILED at %0t: retire_o.we/illegal_o expected 0/0 got %0b/%0b", $time,
                   $sampled(retire_i.we), $sampled(illegal_i));
        end

endmodule

bind int_core int_core_checker #(
    .NUM_REGS(NUM_REGS)
) i_int_core_checker (
    .clk          (clk),
    .rst_i        (rst_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .retire_i     (retire_o),
    .illegal_i    (illegal_o)
);

/* verilog/int_core.sv */
/*
 integer execute slice
 decode stage, bypassed register file and execute stage, two
 edges from instruction strobe to retirement or illegal pulse
 */

`timescale 1ns/10ps

module int_core #(
    // 16 for the embedded base
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 instr_valid_i,
    input  rv_core_pkg::instr_u  instr_i,
    output rv_core_pkg::wb_req_t retire_o,
    output logic                 illegal_o
);

    localparam int AW = $clog2(NUM_REGS);

    // id to regs
    logic [AW-1:0]          raddr1;
    logic [AW-1:0]          raddr2;
    // regs to id
    rv_core_pkg::reg_data_t rdata1;
    rv_core_pkg::reg_data_t rdata2;
    // id to ex
    rv_core_pkg::dec_op_t   dec_op;
    // ex to regs
    rv_core_pkg::wb_req_t   wb_req;

    id_stage #(
        .NUM_REGS(NUM_REGS)
    ) i_id_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .dec_op_o     (dec_op)
    );

    reg_file #(
        .NUM_REGS(NUM_REGS)
    ) i_reg_file (
        .clk     (clk),
        .rst_i   (rst_i),
        .wb_req_i(wb_req),
        .raddr1_i(raddr1),
        .raddr2_i(raddr2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

    ex_stage i_ex_stage (
        .clk      (clk),
        .rst_i    (rst_i),
        .dec_op_i (dec_op),
        .wb_req_o (wb_req),
        .retire_o (retire_o),
        .illegal_o(illegal_o)
    );

endmodule

/* verilog/ex_stage.sv */
/*
 execute stage
 ALU over the decoded operands, issues the write-back request
 and registers the retirement record and the illegal pulse
 */

`timescale 1ns/10ps

module ex_stage (
    input  logic                 clk,
    input  logic                 rst_i,
    input  rv_core_pkg::dec_op_t dec_op_i,
    output rv_core_pkg::wb_req_t wb_req_o,
    output rv_core_pkg::wb_req_t retire_o,
    output logic                 illegal_o
);

    rv_core_pkg::reg_data_t alu_res;
    logic                   slt_bit;

    // retirement flops, we and illegal reset
    logic                   ret_we_q;
    logic [4:0]             ret_rd_q;
    rv_core_pkg::reg_data_t ret_wdata_q;
    logic                   illegal_q;

    // signed compare for SLT and SLTI
    assign slt_bit = $signed(dec_op_i.op_a) < $signed(dec_op_i.op_b);

    always_comb begin
        case (dec_op_i.alu_op)
            rv_core_pkg::ALU_ADD: alu_res = dec_op_i.op_a + dec_op_i.op_b;
            rv_core_pkg::ALU_SUB: alu_res = dec_op_i.op_a - dec_op_i.op_b;
            rv_core_pkg::ALU_AND: alu_res = dec_op_i.op_a & dec_op_i.op_b;
            rv_core_pkg::ALU_OR:  alu_res = dec_op_i.op_a | dec_op_i.op_b;
            rv_core_pkg::ALU_XOR: alu_res = dec_op_i.op_a ^ dec_op_i.op_b;
            rv_core_pkg::ALU_SLT: alu_res = {{(rv_core_pkg::XLEN-1){1'b0}}, slt_bit};
            default:              alu_res = dec_op_i.op_a + dec_op_i.op_b;
        endcase
    end

    // write-back this cycle, feeds the register file bypass
    assign wb_req_o = '{we: dec_op_i.valid & ~dec_op_i.illegal,
                        rd: dec_op_i.rd,
                        wdata: alu_res};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ret_we_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            ret_we_q  <= wb_req_o.we;
            illegal_q <= dec_op_i.valid & dec_op_i.illegal;
        end
    end

    // payload only meaningful with ret_we_q
    always_ff @(posedge clk) begin
        ret_rd_q    <= wb_req_o.rd;
        ret_wdata_q <= wb_req_o.wdata;
    end

    assign retire_o  = '{we: ret_we_q, rd: ret_rd_q, wdata: ret_wdata_q};
    assign illegal_o = illegal_q;

endmodule

/* verilog/reg_file.sv */
/*
 general register file
 x1..x(NUM_REGS-1) storage with one write port and two read ports,
 x0 reads zero, reads of a register being written return the
 write data in the same cycle
 */

`timescale 1ns/10ps

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  rv_core_pkg::wb_req_t        wb_req_i,
    input  logic [$clog2(NUM_REGS)-1:0] raddr1_i,
    input  logic [$clog2(NUM_REGS)-1:0] raddr2_i,
    output rv_core_pkg::reg_data_t      rdata1_o,
    output rv_core_pkg::reg_data_t      rdata2_o
);

    localparam int AW = $clog2(NUM_REGS);

    // no storage behind x0
    rv_core_pkg::reg_data_t regs_q [1:NUM_REGS-1];

    logic [AW-1:0] waddr;
    logic          wr_en;

    // decoder keeps rd in range for any request with we set
    assign waddr = wb_req_i.rd[AW-1:0];
    assign wr_en = wb_req_i.we && (wb_req_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[waddr] <= wb_req_i.wdata;
        end
    end

    // zero first, then write bypass, then storage
    function automatic rv_core_pkg::reg_data_t read_port(input logic [AW-1:0] addr);
        rv_core_pkg::reg_data_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wr_en && (addr == waddr)) begin
            val = wb_req_i.wdata;
        end else begin
            val = regs_q[addr];
        end
        return val;
    endfunction

    // both ports identical
    // reads follow storage and the pending write as well as the address
    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

/* verilog/id_stage.sv */
/*
 decode stage
 splits the instruction word, drives the register read addresses
 and registers the decoded operation together with its operands
 */

`timescale 1ns/10ps

module id_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        instr_valid_i,
    input  rv_core_pkg::instr_u         instr_i,
    output logic [$clog2(NUM_REGS)-1:0] raddr1_o,
    output logic [$clog2(NUM_REGS)-1:0] raddr2_o,
    input  rv_core_pkg::reg_data_t      rdata1_i,
    input  rv_core_pkg::reg_data_t      rdata2_i,
    output rv_core_pkg::dec_op_t        dec_op_o
);

    localparam int AW = $clog2(NUM_REGS);

    rv_core_pkg::alu_op_e   alu_op_d;
    logic                   illegal_d;
    logic                   use_imm_d;
    logic                   reg_bad_d;
    rv_core_pkg::reg_data_t imm_sext;
    rv_core_pkg::reg_data_t op_b_d;

    // control flops, reset
    logic                   valid_q;
    logic                   illegal_q;
    // payload flops, loaded per instruction
    rv_core_pkg::alu_op_e   alu_op_q;
    logic [4:0]             rd_q;
    rv_core_pkg::reg_data_t op_a_q;
    rv_core_pkg::reg_data_t op_b_q;

    // read addresses straight from the word, rs2 slot unused by I-type
    assign raddr1_o = instr_i.r.rs1[AW-1:0];
    assign raddr2_o = instr_i.r.rs2[AW-1:0];

    // I-type view
    assign imm_sext = {{(rv_core_pkg::XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

    always_comb begin
        alu_op_d  = rv_core_pkg::ALU_ADD;
        illegal_d = 1'b0;
        use_imm_d = 1'b0;
        // rd and rs1 sit at the same place in both views
        reg_bad_d = (int'(instr_i.r.rd) >= NUM_REGS) || (int'(instr_i.r.rs1) >= NUM_REGS);
        case (instr_i.r.opcode)
            rv_core_pkg::OPC_OP: begin
                // rs2 only matters for the register form
                reg_bad_d = reg_bad_d || (int'(instr_i.r.rs2) >= NUM_REGS);
                case ({instr_i.r.funct7, instr_i.r.funct3})
                    {7'b0000000, rv_core_pkg::F3_ADD}: alu_op_d = rv_core_pkg::ALU_ADD;
                    {rv_core_pkg::F7_SUB, rv_core_pkg::F3_ADD}: alu_op_d = rv_core_pkg::ALU_SUB;
                    {7'b0000000, rv_core_pkg::F3_SLT}: alu_op_d = rv_core_pkg::ALU_SLT;
                    {7'b0000000, rv_core_pkg::F3_XOR}: alu_op_d = rv_core_pkg::ALU_XOR;
                    {7'b0000000, rv_core_pkg::F3_OR}:  alu_op_d = rv_core_pkg::ALU_OR;
                    {7'b0000000, rv_core_pkg::F3_AND}: alu_op_d = rv_core_pkg::ALU_AND;
                    default: illegal_d = 1'b1;
                endcase
            end
            rv_core_pkg::OPC_OP_IMM: begin
                use_imm_d = 1'b1;
                case (instr_i.i.funct3)
                    rv_core_pkg::F3_ADD: alu_op_d = rv_core_pkg::ALU_ADD;
                    rv_core_pkg::F3_SLT: alu_op_d = rv_core_pkg::ALU_SLT;
                    rv_core_pkg::F3_XOR: alu_op_d = rv_core_pkg::ALU_XOR;
                    rv_core_pkg::F3_OR:  alu_op_d = rv_core_pkg::ALU_OR;
                    rv_core_pkg::F3_AND: alu_op_d = rv_core_pkg::ALU_AND;
                    // shifts and SLTIU not supported
                    default: illegal_d = 1'b1;
                endcase
            end
            default: illegal_d = 1'b1;
        endcase
        // register index beyond the file
        illegal_d = illegal_d || reg_bad_d;
    end

    assign op_b_d = use_imm_d ? imm_sext : rdata2_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= instr_valid_i;
            illegal_q <= instr_valid_i & illegal_d;
        end
    end

    // operands captured with bypassed read data
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            alu_op_q <= alu_op_d;
            rd_q     <= instr_i.r.rd;
            op_a_q   <= rdata1_i;
            op_b_q   <= op_b_d;
        end
    end

    assign dec_op_o = '{valid: valid_q, illegal: illegal_q, alu_op: alu_op_q,
                        rd: rd_q, op_a: op_a_q, op_b: op_b_q};

endmodule

/* verilog/rv_core_pkg.sv */
/*
 rv core package
 shared widths, RV32 opcode and funct codes, the instruction word
 with its R-type and I-type views, ALU operation codes and the
 structs passed between the decode and execute stages
 */

package rv_core_pkg;

    // data path width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] reg_data_t;

    // major opcodes, register and immediate arithmetic
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 codes
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 selecting SUB over ADD
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic      valid;
        logic      illegal;
        alu_op_e   alu_op;
        logic [4:0] rd;
        reg_data_t op_a;
        reg_data_t op_b;
    } dec_op_t;

    // write-back request, also the retirement record
    typedef struct packed {
        logic       we;
        logic [4:0] rd;
        reg_data_t  wdata;
    } wb_req_t;

endpackage
